// File: logic/cam_bist_pkg.sv
/*
  Sizes, selector codes and test keys for the 32 x 12 binary CAM self test.
  The fold count assumes cam_entries is larger than cam_dwidth.
*/
`default_nettype none

package cam_bist_pkg;

  // ==============================
  // Array geometry
  // ==============================
  localparam int cam_entries = 32;
  localparam int cam_dwidth  = 12;
  localparam int cam_awidth  = 5;
  // Whole folds of the match vector onto the data path
  localparam int cam_fold    = cam_entries / cam_dwidth;
  // Search strobe to valid match lines
  localparam int cam_lat     = 2;

  // Expected match vector selectors
  localparam logic [1:0] sel_all_match       = 2'b00;
  localparam logic [1:0] sel_single_match    = 2'b01;
  localparam logic [1:0] sel_single_mismatch = 2'b10;
  localparam logic [1:0] sel_all_mismatch    = 2'b11;

  // Test data
  localparam logic [cam_dwidth-1:0] bist_background = '0;
  localparam logic [cam_dwidth-1:0] bist_miss_key   = '1;

  // Unique per entry, MSB set so it never equals the background
  function automatic logic [cam_dwidth-1:0] bist_entry_key(input logic [cam_awidth-1:0] addr);
    logic [cam_dwidth-1:0] key;
    key = '0;
    key[cam_dwidth-1] = 1'b1;
    key[cam_awidth-1:0] = addr;
    return key;
  endfunction

  typedef enum logic [3:0] {
    st_idle, st_fill, st_search_all, st_walk_write, st_walk_hit,
    st_walk_miss, st_walk_restore, st_search_none, st_drain, st_done
  } bist_state_t;

endpackage

`default_nettype wire

// File: logic/cam_test_if.sv
/*
  Array test controls. One instance per driver, the top level muxes them.
*/
`timescale 1ns/1ns
`default_nettype none

interface cam_test_if;
  import cam_bist_pkg::*;

  // Compare mode and expected vector select
  logic                  cm_mode;
  logic [1:0]            match_sel;
  logic [cam_awidth-1:0] search_addr;

  // Write port
  logic                  wr_en;
  logic [cam_awidth-1:0] wr_addr;
  logic [cam_dwidth-1:0] wr_data;

  // Search port
  logic                  search_en;
  logic [cam_dwidth-1:0] search_key;

  // Read port
  logic                  rd_en;
  logic [cam_awidth-1:0] rd_addr;

  modport ctrl (output cm_mode, match_sel, search_addr, wr_en, wr_addr, wr_data,
                output search_en, search_key, rd_en, rd_addr);
  modport array (input wr_en, wr_addr, wr_data, search_en, search_key, rd_en, rd_addr);
  modport handler (input cm_mode, match_sel, search_addr);

endinterface

`default_nettype wire

// File: logic/bcam_array.sv
/*
  Behavioral binary CAM, single write, search and read port.
  Match lines valid two edges after the search strobe, read data one edge.
  Entries hold no reset value, only the valid bits clear.
*/
`timescale 1ns/1ns
`default_nettype none

module bcam_array (
  input  logic                                bist_clk,
  input  logic                                rst,
  cam_test_if.array                           tst,
  output logic [cam_bist_pkg::cam_entries-1:0] match_lines,
  output logic [cam_bist_pkg::cam_dwidth-1:0]  rd_data
);
  import cam_bist_pkg::*;

  // Storage
  logic [cam_dwidth-1:0]  mem [cam_entries];
  logic [cam_entries-1:0] valid;

  // Search pipeline
  logic [cam_dwidth-1:0]  key_q;
  logic                   srch_q;
  logic [cam_entries-1:0] hit;

  // ==============================
  // Per-entry compare
  // ==============================
  always_comb begin
    for (int i = 0; i < cam_entries; i++) begin
      // Unwritten entries never match
      hit[i] = valid[i] && (mem[i] == key_q);
    end
  end

  // ==============================
  // Control state
  // ==============================
  always_ff @(posedge bist_clk) begin
    if (rst) begin
      valid       <= '0;
      srch_q      <= 1'b0;
      match_lines <= '0;
    end else begin
      if (tst.wr_en) begin
        valid[tst.wr_addr] <= 1'b1;
      end
      srch_q <= tst.search_en;
      // Second stage, lines hold until the next search
      if (srch_q) begin
        match_lines <= hit;
      end
    end
  end

  // ==============================
  // Data path
  // ==============================
  always_ff @(posedge bist_clk) begin
    if (tst.wr_en) begin
      mem[tst.wr_addr] <= tst.wr_data;
    end
    // First search stage
    if (tst.search_en) begin
      key_q <= tst.search_key;
    end
    if (tst.rd_en) begin
      rd_data <= mem[tst.rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: logic/cam_bist_outhandler.sv
/*
  Match compare and compaction for the CAM self test.
  match_sel is used live, the driver holds it through the compare.
  Compaction is lossy, a zero result only means no difference was seen.
*/
`timescale 1ns/1ns
`default_nettype none

module cam_bist_outhandler (
  input  logic                                 bist_clk,
  cam_test_if.handler                          tst,
  input  logic [cam_bist_pkg::cam_entries-1:0] match_lines,
  input  logic [cam_bist_pkg::cam_dwidth-1:0]  rd_data_in,
  output logic [cam_bist_pkg::cam_dwidth-1:0]  rd_data_out,
  output logic [cam_bist_pkg::cam_entries-1:0] match_ref
);
  import cam_bist_pkg::*;

  logic [cam_awidth-1:0]  addr_d1;
  logic [cam_awidth-1:0]  addr_d2;
  logic [cam_entries-1:0] one_hot;
  logic [cam_entries-1:0] exp_vec;
  logic [cam_entries-1:0] diff;
  logic [cam_dwidth-1:0]  cmp_data;

  // ==============================
  // Expected match vector
  // ==============================

  // Two stages to line up with the array match pipeline
  always_ff @(posedge bist_clk) begin
    addr_d1 <= tst.search_addr;
    addr_d2 <= addr_d1;
  end

  assign one_hot = {{(cam_entries-1){1'b0}}, 1'b1} << addr_d2;

  always_comb begin
    case (tst.match_sel)
      sel_all_match:       exp_vec = '1;
      sel_single_match:    exp_vec = one_hot;
      sel_single_mismatch: exp_vec = ~one_hot;
      default:             exp_vec = '0;
    endcase
  end

  assign match_ref = exp_vec;

  // Any set bit is an entry that disagrees with the expectation
  assign diff = exp_vec ^ match_lines;

  // ==============================
  // Compaction onto the data width
  // ==============================
  generate
    if (cam_dwidth < cam_entries) begin : g_compact
      logic [cam_dwidth-1:0] folded;

      // OR the whole folds together
      always_comb begin
        folded = '0;
        for (int f = 0; f < cam_fold; f++) begin
          folded = folded | diff[f*cam_dwidth +: cam_dwidth];
        end
      end

      if ((cam_entries % cam_dwidth) != 0) begin : g_rem
        // Leftover entries land on the top bits
        assign cmp_data = folded |
          {diff[cam_entries-1:cam_fold*cam_dwidth],
           {((cam_fold+1)*cam_dwidth-cam_entries){1'b0}}};
      end else begin : g_even
        assign cmp_data = folded;
      end
    end else if (cam_dwidth == cam_entries) begin : g_equal
      assign cmp_data = diff[cam_dwidth-1:0];
    end else begin : g_expand
      // Narrow vector sits in the upper data bits
      assign cmp_data = {diff, {(cam_dwidth-cam_entries){1'b0}}};
    end
  endgenerate

  // Compare result replaces array read data in compare mode
  assign rd_data_out = tst.cm_mode ? cmp_data : rd_data_in;

endmodule

`default_nettype wire

// File: logic/cam_mbist_ctrl.sv
/*
  CAM self test sequencer. start is a level, done holds until start falls.
  A new search waits until the previous check has been sampled.
  fail stays set until the next start.
*/
`timescale 1ns/1ns
`default_nettype none

module cam_mbist_ctrl (
  input  logic                                 bist_clk,
  input  logic                                 rst,
  input  logic                                 start,
  cam_test_if.ctrl                             tst,
  input  logic [cam_bist_pkg::cam_dwidth-1:0]  rd_data_out,
  input  logic [cam_bist_pkg::cam_entries-1:0] match_ref,
  output logic                                 busy,
  output logic                                 done,
  output logic                                 fail,
  output logic [cam_bist_pkg::cam_awidth-1:0]  fail_addr
);
  import cam_bist_pkg::*;

  bist_state_t           state;
  logic [cam_awidth-1:0] entry;
  logic [cam_lat-1:0]    chk_pend;
  logic                  chk_idle;
  logic                  chk_now;

  // Lowest suspect entry behind the first set compacted bit.
  // Prefers the entry singled out by the expected vector
  function automatic logic [cam_awidth-1:0] locate_fail(
    input logic [cam_dwidth-1:0]  cmp,
    input logic [cam_entries-1:0] ref_vec
  );
    int                    p;
    int                    pos;
    logic                  minor;
    logic                  have_low;
    logic                  have_odd;
    logic [cam_awidth-1:0] low_idx;
    logic [cam_awidth-1:0] odd_idx;
    p = 0;
    for (int b = cam_dwidth - 1; b >= 0; b--) begin
      if (cmp[b]) p = b;
    end
    // Value held by the odd entry of a one-hot or one-cold vector
    minor    = ($countones(ref_vec) <= 1);
    have_low = 1'b0;
    have_odd = 1'b0;
    low_idx  = '0;
    odd_idx  = '0;
    for (int i = 0; i < cam_entries; i++) begin
      if (i < cam_fold * cam_dwidth) pos = i % cam_dwidth;
      else pos = i + cam_dwidth - cam_entries;
      if (pos == p) begin
        if (!have_low) begin
          low_idx  = cam_awidth'(i);
          have_low = 1'b1;
        end
        if (!have_odd && (ref_vec[i] == minor)) begin
          odd_idx  = cam_awidth'(i);
          have_odd = 1'b1;
        end
      end
    end
    return have_odd ? odd_idx : low_idx;
  endfunction

  // No search in flight and no check left to sample
  assign chk_idle = !tst.search_en && !(|chk_pend);
  assign chk_now  = chk_pend[cam_lat-1] && tst.cm_mode;

  // Reads are not part of the algorithm
  assign tst.rd_en   = 1'b0;
  assign tst.rd_addr = entry;

  // ==============================
  // Sequencer
  // ==============================
  always_ff @(posedge bist_clk) begin
    if (rst) begin
      state         <= st_idle;
      entry         <= '0;
      busy          <= 1'b0;
      done          <= 1'b0;
      fail          <= 1'b0;
      fail_addr     <= '0;
      chk_pend      <= '0;
      tst.cm_mode   <= 1'b0;
      tst.match_sel <= sel_all_match;
      tst.wr_en     <= 1'b0;
      tst.search_en <= 1'b0;
    end else begin
      tst.wr_en     <= 1'b0;
      tst.search_en <= 1'b0;
      chk_pend      <= {chk_pend[cam_lat-2:0], tst.search_en};

      // Compacted result must be all zero
      if (chk_now && (rd_data_out != '0)) begin
        fail <= 1'b1;
        if (!fail) fail_addr <= locate_fail(rd_data_out, match_ref);
      end

      case (state)
        st_idle: begin
          if (start) begin
            busy        <= 1'b1;
            fail        <= 1'b0;
            fail_addr   <= '0;
            tst.cm_mode <= 1'b1;
            entry       <= '0;
            state       <= st_fill;
          end
        end
        st_fill: begin
          tst.wr_en   <= 1'b1;
          tst.wr_addr <= entry;
          tst.wr_data <= bist_background;
          entry       <= entry + 1'b1;
          if (entry == cam_awidth'(cam_entries - 1)) state <= st_search_all;
        end
        st_search_all: begin
          if (chk_idle) begin
            tst.search_en   <= 1'b1;
            tst.search_key  <= bist_background;
            tst.search_addr <= entry;
            tst.match_sel   <= sel_all_match;
            state           <= st_walk_write;
          end
        end
        st_walk_write: begin
          tst.wr_en   <= 1'b1;
          tst.wr_addr <= entry;
          tst.wr_data <= bist_entry_key(entry);
          state       <= st_walk_hit;
        end
        st_walk_hit: begin
          if (chk_idle) begin
            tst.search_en   <= 1'b1;
            tst.search_key  <= bist_entry_key(entry);
            tst.search_addr <= entry;
            tst.match_sel   <= sel_single_match;
            state           <= st_walk_miss;
          end
        end
        st_walk_miss: begin
          // Only the entry under test lacks the background
          if (chk_idle) begin
            tst.search_en   <= 1'b1;
            tst.search_key  <= bist_background;
            tst.search_addr <= entry;
            tst.match_sel   <= sel_single_mismatch;
            state           <= st_walk_restore;
          end
        end
        st_walk_restore: begin
          // Write lands after the pending search has sampled the array
          tst.wr_en   <= 1'b1;
          tst.wr_addr <= entry;
          tst.wr_data <= bist_background;
          entry       <= entry + 1'b1;
          if (entry == cam_awidth'(cam_entries - 1)) state <= st_search_none;
          else state <= st_walk_write;
        end
        st_search_none: begin
          if (chk_idle) begin
            tst.search_en   <= 1'b1;
            tst.search_key  <= bist_miss_key;
            tst.search_addr <= entry;
            tst.match_sel   <= sel_all_mismatch;
            state           <= st_drain;
          end
        end
        st_drain: begin
          if (chk_idle) begin
            busy        <= 1'b0;
            done        <= 1'b1;
            tst.cm_mode <= 1'b0;
            state       <= st_done;
          end
        end
        default: begin
          if (!start) begin
            done  <= 1'b0;
            state <= st_idle;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/cam_bist_top.sv
/*
  CAM with self test. Functional ports are ignored while bist_busy is high.
  rd_data carries the compacted compare result during a test.
*/
`timescale 1ns/1ns
`default_nettype none

module cam_bist_top (
  input  logic                                 bist_clk,
  input  logic                                 rst,
  input  logic                                 bist_start,
  input  logic                                 wr_en,
  input  logic [cam_bist_pkg::cam_awidth-1:0]  wr_addr,
  input  logic [cam_bist_pkg::cam_dwidth-1:0]  wr_data,
  input  logic                                 search_en,
  input  logic [cam_bist_pkg::cam_dwidth-1:0]  search_key,
  input  logic                                 rd_en,
  input  logic [cam_bist_pkg::cam_awidth-1:0]  rd_addr,
  output logic [cam_bist_pkg::cam_entries-1:0] match_lines,
  output logic [cam_bist_pkg::cam_dwidth-1:0]  rd_data,
  output logic                                 bist_busy,
  output logic                                 bist_done,
  output logic                                 bist_fail,
  output logic [cam_bist_pkg::cam_awidth-1:0]  bist_fail_addr
);
  import cam_bist_pkg::*;

  cam_test_if bist_if ();
  cam_test_if cam_if ();

  // ==============================
  // Functional / test port mux
  // ==============================
  assign cam_if.cm_mode     = bist_busy ? bist_if.cm_mode     : 1'b0;
  assign cam_if.match_sel   = bist_busy ? bist_if.match_sel   : sel_all_match;
  assign cam_if.search_addr = bist_busy ? bist_if.search_addr : '0;
  assign cam_if.wr_en       = bist_busy ? bist_if.wr_en       : wr_en;
  assign cam_if.wr_addr     = bist_busy ? bist_if.wr_addr     : wr_addr;
  assign cam_if.wr_data     = bist_busy ? bist_if.wr_data     : wr_data;
  assign cam_if.search_en   = bist_busy ? bist_if.search_en   : search_en;
  assign cam_if.search_key  = bist_busy ? bist_if.search_key  : search_key;
  assign cam_if.rd_en       = bist_busy ? bist_if.rd_en       : rd_en;
  assign cam_if.rd_addr     = bist_busy ? bist_if.rd_addr     : rd_addr;

  logic [cam_dwidth-1:0]  cam_rd_data;
  logic [cam_entries-1:0] match_ref;

  bcam_array i_bcam_array (
    .bist_clk    (bist_clk),
    .rst         (rst),
    .tst         (cam_if.array),
    .match_lines (match_lines),
    .rd_data     (cam_rd_data)
  );

  cam_bist_outhandler i_cam_bist_outhandler (
    .bist_clk    (bist_clk),
    .tst         (cam_if.handler),
    .match_lines (match_lines),
    .rd_data_in  (cam_rd_data),
    .rd_data_out (rd_data),
    .match_ref   (match_ref)
  );

  cam_mbist_ctrl i_cam_mbist_ctrl (
    .bist_clk    (bist_clk),
    .rst         (rst),
    .start       (bist_start),
    .tst         (bist_if.ctrl),
    .rd_data_out (rd_data),
    .match_ref   (match_ref),
    .busy        (bist_busy),
    .done        (bist_done),
    .fail        (bist_fail),
    .fail_addr   (bist_fail_addr)
  );

endmodule

`default_nettype wire

// File: sim/cam_bist_props.sv
/*
  Controller checks, bound into every cam_mbist_ctrl.
  The fail check assumes a fault-free array.
*/
`timescale 1ns/1ns
`default_nettype none

module cam_bist_props (
  input logic                             bist_clk,
  input logic                             rst,
  input logic                             busy,
  input logic                             done,
  input logic                             fail,
  input logic [1:0]                       match_sel,
  input logic [cam_bist_pkg::cam_lat-1:0] chk_pend
);
  import cam_bist_pkg::*;

  // Failed assertions, read by the testbench at the end
  int fail_count = 0;

  // Selector feeds the live compare, it must hold until the check is sampled
  a_sel_stable: assert property (@(posedge bist_clk) disable iff (rst)
    (|chk_pend) |-> $stable(match_sel))
    else begin
      $error("match_sel changed while a check was pending");
      fail_count++;
    end

  a_done_idle: assert property (@(posedge bist_clk) disable iff (rst)
    done |-> !busy)
    else begin
      $error("done is high while busy is high");
      fail_count++;
    end

  a_no_fail: assert property (@(posedge bist_clk) disable iff (rst)
    !fail)
    else begin
      $error("fail is set on a fault-free array");
      fail_count++;
    end

endmodule

bind cam_mbist_ctrl cam_bist_props i_cam_bist_props (
  .bist_clk  (bist_clk),
  .rst       (rst),
  .busy      (busy),
  .done      (done),
  .fail      (fail),
  .match_sel (tst.match_sel),
  .chk_pend  (chk_pend)
);

`default_nettype wire

// File: sim/cam_bist_tb.sv
/*
  Testbench for the CAM with self test. Inputs change on the falling edge,
  results are sampled a quarter period after the rising edge.
  Reads of never written entries are not checked.
*/
`timescale 1ns/1ns
`default_nettype none

module cam_bist_tb;
  import cam_bist_pkg::*;

  localparam int clk_half   = 50;
  // About 300 cycles of BIST plus about 200 of functional traffic, with margin
  localparam int max_cycles = 3000;

  logic                   bist_clk;
  logic                   rst;
  logic                   bist_start;
  logic                   wr_en;
  logic [cam_awidth-1:0]  wr_addr;
  logic [cam_dwidth-1:0]  wr_data;
  logic                   search_en;
  logic [cam_dwidth-1:0]  search_key;
  logic                   rd_en;
  logic [cam_awidth-1:0]  rd_addr;
  logic [cam_entries-1:0] match_lines;
  logic [cam_dwidth-1:0]  rd_data;
  logic                   bist_busy;
  logic                   bist_done;
  logic                   bist_fail;
  logic [cam_awidth-1:0]  bist_fail_addr;

  // Reference CAM
  logic [cam_dwidth-1:0]  model_mem [cam_entries];
  logic [cam_entries-1:0] model_valid;
  logic                   busy_prev;
  logic                   srch_pend;
  logic [cam_entries-1:0] srch_exp;

  integer      seed;
  logic [31:0] rnd;
  string       test_name;
  int          errors;
  int          checks;

  cam_bist_top i_cam_bist_top (
    .bist_clk       (bist_clk),
    .rst            (rst),
    .bist_start     (bist_start),
    .wr_en          (wr_en),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .search_en      (search_en),
    .search_key     (search_key),
    .rd_en          (rd_en),
    .rd_addr        (rd_addr),
    .match_lines    (match_lines),
    .rd_data        (rd_data),
    .bist_busy      (bist_busy),
    .bist_done      (bist_done),
    .bist_fail      (bist_fail),
    .bist_fail_addr (bist_fail_addr)
  );

  always #clk_half bist_clk = ~bist_clk;

  // Valid entries holding the key
  function automatic logic [cam_entries-1:0] expected_match(input logic [cam_dwidth-1:0] k);
    logic [cam_entries-1:0] v;
    v = '0;
    for (int i = 0; i < cam_entries; i++) begin
      if (model_valid[i] && (model_mem[i] == k)) begin
        v[i] = 1'b1;
      end
    end
    return v;
  endfunction

  // ==============================
  // Compare process
  // ==============================
  always @(posedge bist_clk) begin
    #(clk_half / 2);
    if (rst) begin
      model_valid = '0;
      srch_pend   = 1'b0;
      busy_prev   = 1'b0;
    end else begin
      // Search from the previous edge has reached the match lines
      if (srch_pend) begin
        checks++;
        if (match_lines !== srch_exp) begin
          $display("** Error [%s] match_lines: expected %h, actual %h",
                   test_name, srch_exp, match_lines);
          errors++;
        end
        srch_pend = 1'b0;
      end
      // Read sees the contents before a write on the same edge
      if (rd_en && !busy_prev && model_valid[rd_addr]) begin
        checks++;
        if (rd_data !== model_mem[rd_addr]) begin
          $display("** Error [%s] rd_data at %0d: expected %h, actual %h",
                   test_name, rd_addr, model_mem[rd_addr], rd_data);
          errors++;
        end
      end
      // Requests while the BIST owns the array are dropped
      if (wr_en && !busy_prev) begin
        model_mem[wr_addr]   = wr_data;
        model_valid[wr_addr] = 1'b1;
      end
      if (search_en && !busy_prev) begin
        srch_exp  = expected_match(search_key);
        srch_pend = 1'b1;
      end
      // BIST leaves the background in every entry
      if (busy_prev && !bist_busy) begin
        for (int i = 0; i < cam_entries; i++) begin
          model_mem[i] = bist_background;
        end
        model_valid = '1;
      end
      busy_prev = bist_busy;
    end
  end

  // ==============================
  // Stimulus tasks
  // ==============================
  task automatic clear_strobes();
    wr_en     = 1'b0;
    search_en = 1'b0;
    rd_en     = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge bist_clk);
      clear_strobes();
    end
  endtask

  task automatic write_entry(input logic [cam_awidth-1:0] a, input logic [cam_dwidth-1:0] d);
    @(negedge bist_clk);
    clear_strobes();
    wr_en   = 1'b1;
    wr_addr = a;
    wr_data = d;
  endtask

  task automatic read_entry(input logic [cam_awidth-1:0] a);
    @(negedge bist_clk);
    clear_strobes();
    rd_en   = 1'b1;
    rd_addr = a;
  endtask

  task automatic issue_search(input logic [cam_dwidth-1:0] k);
    @(negedge bist_clk);
    clear_strobes();
    search_en  = 1'b1;
    search_key = k;
  endtask

  // ==============================
  // Watchdog
  // ==============================
  initial begin
    repeat (max_cycles) @(posedge bist_clk);
    $display("Timeout: the run did not finish within %0d clock cycles", max_cycles);
    $display("FAIL: see errors above");
    $finish;
  end

  // ==============================
  // Test sequence
  // ==============================
  initial begin
    seed       = 32'h6dd6b3a8;
    errors     = 0;
    checks     = 0;
    test_name  = "reset";
    bist_clk   = 1'b0;
    rst        = 1'b1;
    bist_start = 1'b0;
    wr_en      = 1'b0;
    wr_addr    = '0;
    wr_data    = '0;
    search_en  = 1'b0;
    search_key = '0;
    rd_en      = 1'b0;
    rd_addr    = '0;
    repeat (8) @(negedge bist_clk);
    rst = 1'b0;
    idle_cycles(2);

    // Random writes, then read every entry
    test_name = "write_read";
    for (int n = 0; n < 40; n++) begin
      rnd = $random(seed);
      write_entry(rnd[4:0], rnd[27:16]);
    end
    for (int a = 0; a < cam_entries; a++) begin
      read_entry(cam_awidth'(a));
    end
    idle_cycles(3);

    // Stored keys half the time, random keys otherwise
    test_name = "search";
    for (int n = 0; n < 40; n++) begin
      rnd = $random(seed);
      if (rnd[31] && model_valid[rnd[4:0]]) issue_search(model_mem[rnd[4:0]]);
      else issue_search(rnd[27:16]);
    end
    idle_cycles(3);

    test_name = "bist";
    @(negedge bist_clk);
    bist_start = 1'b1;
    wait (bist_busy);
    // Functional traffic during the test must not reach the array
    test_name = "ignored_ops";
    for (int n = 0; n < 6; n++) begin
      rnd = $random(seed);
      write_entry(rnd[4:0], rnd[27:16]);
      issue_search(rnd[27:16]);
    end
    idle_cycles(1);
    if (!bist_busy) begin
      $display("BIST finished before the functional traffic phase ended");
      errors++;
    end
    test_name = "bist";
    wait (bist_done);
    @(negedge bist_clk);
    checks++;
    if (bist_fail !== 1'b0) begin
      $display("** Error [%s] bist_fail: expected 0, actual %b", test_name, bist_fail);
      errors++;
    end
    checks++;
    if (bist_busy !== 1'b0) begin
      $display("** Error [%s] bist_busy: expected 0, actual %b", test_name, bist_busy);
      errors++;
    end
    // No failure seen, so no failing entry is recorded
    checks++;
    if (bist_fail_addr !== '0) begin
      $display("** Error [%s] bist_fail_addr: expected 0, actual %0d",
               test_name, bist_fail_addr);
      errors++;
    end
    bist_start = 1'b0;
    wait (!bist_done);
    idle_cycles(2);

    // Every entry holds the background now
    test_name = "after_bist";
    for (int a = 0; a < cam_entries; a++) begin
      read_entry(cam_awidth'(a));
    end
    issue_search(bist_background);
    issue_search(bist_miss_key);
    idle_cycles(4);

    errors = errors + i_cam_bist_top.i_cam_mbist_ctrl.i_cam_bist_props.fail_count;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
logic/cam_bist_pkg.sv
logic/cam_test_if.sv
logic/bcam_array.sv
logic/cam_bist_outhandler.sv
logic/cam_mbist_ctrl.sv
logic/cam_bist_top.sv
sim/cam_bist_props.sv
sim/cam_bist_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the CAM self test simulation with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
  -f project.f --top-module cam_bist_tb -o cam_bist_sim

# Keep running after an assertion error so the testbench can report it
./obj_dir/cam_bist_sim +verilator+error+limit+100 | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation passed"
